//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - mem_rw_if.sv
      - store_lane_align.sv
      - mem_stage.sv
      - data_ram.sv
      - mem_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_chk.sv
      - mem_tb.sv

//--- data_ram.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module data_ram (
  input logic     clk,
  input logic     rst,
  mem_rw_if.slave mem
);
  import mem_pkg::*;

  localparam int IDX_W = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(`RAM_WAIT + 2);

  xlen_t            ram [`RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] idx;
  logic             xfer;
  xlen_t            lane_data;
  byte_mask_t       lane_mask;

  // word index sits above the byte offset
  assign idx = mem.addr[IDX_W+2:3];

  assign mem.ready = mem.valid && (wait_cnt == CNT_W'(`RAM_WAIT));
  assign xfer      = mem.valid && mem.ready;

  // counts request cycles until ready
  always_ff @(posedge clk) begin
    if (rst || xfer) begin
      wait_cnt <= '0;
    end else if (mem.valid) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // whole word shifted down so the addressed byte lands in lane 0
  assign mem.rdata = ram[idx] >> {mem.addr[2:0], 3'b000};

  store_lane_align u_wr_align (
    .size      (mem.size),
    .addr_low  (mem.addr[2:0]),
    .data      (mem.wdata),
    .lane_data (lane_data),
    .lane_mask (lane_mask)
  );

  always_ff @(posedge clk) begin
    if (xfer && mem.write) begin
      for (int i = 0; i < 8; i++) begin
        if (lane_mask[i]) begin
          ram[idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- files.f
+incdir+.
mem_pkg.sv
mem_rw_if.sv
store_lane_align.sv
mem_stage.sv
data_ram.sv
mem_top.sv
mem_chk.sv
mem_tb.sv

//--- mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// data and address width
`define XLEN 64

// 64-bit words in the data RAM
`define RAM_WORDS 256

// cycles from request valid to RAM ready
`define RAM_WAIT 2

`endif

//--- mem_chk.sv
`timescale 1ns/1ps

module mem_chk (
  input logic                clk,
  input logic                rst,
  input logic                req_valid,
  input logic                req_ready,
  input logic                req_write,
  input mem_pkg::xlen_t      req_addr,
  input mem_pkg::xlen_t      req_wdata,
  input mem_pkg::mem_size_e  req_size,
  input logic                mem_allowin,
  input logic                wb_valid,
  input logic                wb_allowin,
  input mem_pkg::xlen_t      wb_data,
  input mem_pkg::xlen_t      trace_data,
  input mem_pkg::byte_mask_t trace_mask
);

  // failed assertions so far
  int fail_cnt;

  // request stays up and unchanged until the RAM takes it
  a_req_hold: assert property (
    @(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req_addr) && $stable(req_wdata)
      && $stable(req_write) && $stable(req_size)
  ) else begin
    fail_cnt++;
    $error("memory request dropped or changed before ready");
  end

  // writeback side held under back-pressure
  a_wb_hold: assert property (
    @(posedge clk) disable iff (rst)
    wb_valid && !wb_allowin |=> wb_valid && $stable(wb_data) && $stable(trace_data)
      && $stable(trace_mask)
  ) else begin
    fail_cnt++;
    $error("writeback outputs changed while wb_allowin was low");
  end

  a_reset_state: assert property (
    @(posedge clk) $fell(rst) |-> mem_allowin && !wb_valid
  ) else begin
    fail_cnt++;
    $error("stage not empty in the first cycle after reset");
  end

endmodule

bind mem_stage mem_chk i_chk (
  .clk         (clk),
  .rst         (rst),
  .req_valid   (mem.valid),
  .req_ready   (mem.ready),
  .req_write   (mem.write),
  .req_addr    (mem.addr),
  .req_wdata   (mem.wdata),
  .req_size    (mem.size),
  .mem_allowin (mem_allowin),
  .wb_valid    (wb_valid),
  .wb_allowin  (wb_allowin),
  .wb_data     (wb_data),
  .trace_data  (trace_data),
  .trace_mask  (trace_mask)
);

//--- mem_golden.txt
# op addr store_data rd rd_we stall exp_wb_data exp_trace_mask exp_trace_data (all hex)
b 0000000000000100 0123456789abcdef 00 0 0 0000000000000100 ff 0123456789abcdef
b 0000000000000108 f1e2d3c4b5a69788 00 0 1 0000000000000108 ff f1e2d3c4b5a69788
4 0000000000000100 0000000000000000 05 1 0 0123456789abcdef 00 0000000000000000
4 0000000000000108 0000000000000000 06 1 2 f1e2d3c4b5a69788 00 0000000000000000
1 0000000000000108 0000000000000000 07 1 0 ffffffffffffff88 00 0000000000000000
2 000000000000010a 0000000000000000 08 1 0 ffffffffffffb5a6 00 0000000000000000
3 000000000000010c 0000000000000000 09 1 0 fffffffff1e2d3c4 00 0000000000000000
5 000000000000010f 0000000000000000 0a 1 0 00000000000000f1 00 0000000000000000
6 0000000000000108 0000000000000000 0b 1 1 0000000000009788 00 0000000000000000
7 0000000000000108 0000000000000000 0c 1 0 00000000b5a69788 00 0000000000000000
8 0000000000000100 deadbeefcafeba11 00 0 0 0000000000000100 01 0000000000000011
8 0000000000000101 deadbeefcafeba22 00 0 0 0000000000000101 02 0000000000002200
8 0000000000000102 deadbeefcafeba33 00 0 0 0000000000000102 04 0000000000330000
8 0000000000000103 deadbeefcafeba44 00 0 0 0000000000000103 08 0000000044000000
8 0000000000000104 deadbeefcafeba55 00 0 0 0000000000000104 10 0000005500000000
8 0000000000000105 deadbeefcafeba66 00 0 3 0000000000000105 20 0000660000000000
8 0000000000000106 deadbeefcafeba77 00 0 0 0000000000000106 40 0077000000000000
8 0000000000000107 deadbeefcafeba88 00 0 0 0000000000000107 80 8800000000000000
9 0000000000000100 ffffffffffff1a2b 00 0 0 0000000000000100 03 0000000000001a2b
9 0000000000000102 ffffffffffff3c4d 00 0 0 0000000000000102 0c 000000003c4d0000
4 0000000000000100 0000000000000000 0d 1 0 887766553c4d1a2b 00 0000000000000000
9 0000000000000104 0000000000007081 00 0 0 0000000000000104 30 0000708100000000
9 0000000000000106 0000000000005e6f 00 0 2 0000000000000106 c0 5e6f000000000000
4 0000000000000100 0000000000000000 0e 1 0 5e6f70813c4d1a2b 00 0000000000000000
a 000000000000010c 000000000badf00d 00 0 0 000000000000010c f0 0badf00d00000000
4 0000000000000108 0000000000000000 0f 1 1 0badf00db5a69788 00 0000000000000000
a 0000000000000108 aaaaaaaa99887766 00 0 0 0000000000000108 0f 0000000099887766
0 0000000000abcdef 0000000000000000 1f 1 1 0000000000abcdef 00 0000000000000000

//--- mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [4:0]       reg_addr_t;
  typedef logic [7:0]       byte_mask_t;

  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LH   = 4'd2,
    LW   = 4'd3,
    LD   = 4'd4,
    LBU  = 4'd5,
    LHU  = 4'd6,
    LWU  = 4'd7,
    SB   = 4'd8,
    SH   = 4'd9,
    SW   = 4'd10,
    SD   = 4'd11
  } mem_op_e;

  // access size in bytes: 1, 2, 4, 8
  typedef enum logic [1:0] {
    SIZE_B = 2'b00,
    SIZE_H = 2'b01,
    SIZE_W = 2'b10,
    SIZE_D = 2'b11
  } mem_size_e;

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ADDR = 2'b01,
    RETN = 2'b10
  } stage_state_e;

endpackage

//--- mem_rw_if.sv
`timescale 1ns/1ps

interface mem_rw_if;
  import mem_pkg::*;

  logic      valid;
  logic      ready;
  logic      write;
  xlen_t     addr;
  xlen_t     wdata;
  xlen_t     rdata;
  mem_size_e size;

  // stage side
  modport master (
    output valid, write, addr, wdata, size,
    input  ready, rdata
  );

  // RAM side
  modport slave (
    input  valid, write, addr, wdata, size,
    output ready, rdata
  );

endinterface

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                ex_valid,
  input  mem_pkg::xlen_t      ex_pc,
  input  mem_pkg::mem_op_e    ex_op,
  input  mem_pkg::xlen_t      ex_addr,
  input  mem_pkg::xlen_t      ex_store_data,
  input  mem_pkg::reg_addr_t  ex_rd_addr,
  input  logic                ex_rd_we,
  output logic                mem_allowin,
  output logic                wb_valid,
  output mem_pkg::xlen_t      wb_pc,
  output mem_pkg::reg_addr_t  wb_rd_addr,
  output logic                wb_rd_we,
  output mem_pkg::xlen_t      wb_data,
  input  logic                wb_allowin,
  output mem_pkg::reg_addr_t  fwd_rd_addr,
  output logic                fwd_rd_we,
  output logic                fwd_is_load,
  output mem_pkg::xlen_t      fwd_data,
  output logic                trace_st_valid,
  output mem_pkg::xlen_t      trace_addr,
  output mem_pkg::xlen_t      trace_data,
  output mem_pkg::byte_mask_t trace_mask,
  mem_rw_if.master            mem
);
  import mem_pkg::*;

  logic         valid_q;
  mem_op_e      op_q;
  xlen_t        pc_q;
  xlen_t        addr_q;
  xlen_t        sdata_q;
  reg_addr_t    rd_addr_q;
  logic         rd_we_q;
  xlen_t        load_q;
  xlen_t        load_ext;
  xlen_t        wdata_masked;
  mem_size_e    size;
  stage_state_e state;
  stage_state_e state_nxt;
  logic         accept;
  logic         xfer;
  logic         ready_go;
  logic         is_load;
  logic         is_store;
  logic         ex_is_mem;

  function automatic logic op_is_load(mem_op_e op);
    return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return op inside {SB, SH, SW, SD};
  endfunction

  function automatic mem_size_e op_size(mem_op_e op);
    case (op)
      LB, LBU, SB: return SIZE_B;
      LH, LHU, SH: return SIZE_H;
      LW, LWU, SW: return SIZE_W;
      default:     return SIZE_D;
    endcase
  endfunction

  assign accept    = ex_valid && mem_allowin;
  assign xfer      = mem.valid && mem.ready;
  assign is_load   = op_is_load(op_q);
  assign is_store  = op_is_store(op_q);
  assign ex_is_mem = op_is_load(ex_op) || op_is_store(ex_op);
  assign size      = op_size(op_q);

  // non-memory ops finish at once, memory ops once the response is back
  assign ready_go    = (state == RETN) || !(is_load || is_store);
  assign mem_allowin = !valid_q || (ready_go && wb_allowin);
  assign wb_valid    = valid_q && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      op_q    <= NONE;
      state   <= IDLE;
    end else begin
      state <= state_nxt;
      if (mem_allowin) begin
        valid_q <= ex_valid;
      end
      if (accept) begin
        op_q <= ex_op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q      <= ex_pc;
      addr_q    <= ex_addr;
      sdata_q   <= ex_store_data;
      rd_addr_q <= ex_rd_addr;
      rd_we_q   <= ex_rd_we;
    end
    if (xfer) begin
      load_q <= load_ext;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (accept && ex_is_mem) begin
          state_nxt = ADDR;
        end
      end
      ADDR: begin
        if (xfer) begin
          state_nxt = RETN;
        end
      end
      RETN: begin
        if (accept) begin
          state_nxt = ex_is_mem ? ADDR : IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_comb begin
    case (size)
      SIZE_B:  wdata_masked = {56'b0, sdata_q[7:0]};
      SIZE_H:  wdata_masked = {48'b0, sdata_q[15:0]};
      SIZE_W:  wdata_masked = {32'b0, sdata_q[31:0]};
      default: wdata_masked = sdata_q;
    endcase
  end

  // RAM returns the addressed bytes in the low end
  always_comb begin
    case (op_q)
      LB:      load_ext = {{56{mem.rdata[7]}}, mem.rdata[7:0]};
      LH:      load_ext = {{48{mem.rdata[15]}}, mem.rdata[15:0]};
      LW:      load_ext = {{32{mem.rdata[31]}}, mem.rdata[31:0]};
      LBU:     load_ext = {56'b0, mem.rdata[7:0]};
      LHU:     load_ext = {48'b0, mem.rdata[15:0]};
      LWU:     load_ext = {32'b0, mem.rdata[31:0]};
      default: load_ext = mem.rdata;
    endcase
  end

  assign mem.valid = (state == ADDR);
  assign mem.write = is_store;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_masked;
  assign mem.size  = size;

  assign wb_pc      = pc_q;
  assign wb_rd_addr = rd_addr_q;
  assign wb_rd_we   = rd_we_q;
  // address field doubles as the ALU result
  assign wb_data    = is_load ? load_q : addr_q;

  assign fwd_rd_addr = rd_addr_q;
  assign fwd_rd_we   = valid_q && rd_we_q;
  assign fwd_is_load = valid_q && is_load;
  assign fwd_data    = addr_q;

  // store commit trace
  assign trace_st_valid = wb_valid && is_store;
  assign trace_addr     = {addr_q[63:3], 3'b000};

  store_lane_align u_trace_align (
    .size      (size),
    .addr_low  (addr_q[2:0]),
    .data      (wdata_masked),
    .lane_data (trace_data),
    .lane_mask (trace_mask)
  );

endmodule

//--- mem_tb.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_tb;
  import mem_pkg::*;

  localparam int  MAX_OPS = 64;
  localparam time PERIOD  = 40;
  localparam int  HS_CAP  = `RAM_WAIT + 4;

  logic       clk;
  logic       rst;
  logic       ex_valid;
  xlen_t      ex_pc;
  mem_op_e    ex_op;
  xlen_t      ex_addr;
  xlen_t      ex_store_data;
  reg_addr_t  ex_rd_addr;
  logic       ex_rd_we;
  logic       mem_allowin;
  logic       wb_valid;
  xlen_t      wb_pc;
  reg_addr_t  wb_rd_addr;
  logic       wb_rd_we;
  xlen_t      wb_data;
  logic       wb_allowin;
  reg_addr_t  fwd_rd_addr;
  logic       fwd_rd_we;
  logic       fwd_is_load;
  xlen_t      fwd_data;
  logic       trace_st_valid;
  xlen_t      trace_addr;
  xlen_t      trace_data;
  byte_mask_t trace_mask;

  // golden table with one entry per file line
  logic [3:0] g_op    [MAX_OPS];
  xlen_t      g_addr  [MAX_OPS];
  xlen_t      g_sdata [MAX_OPS];
  reg_addr_t  g_rd    [MAX_OPS];
  logic       g_we    [MAX_OPS];
  int         g_stall [MAX_OPS];
  xlen_t      g_wb    [MAX_OPS];
  byte_mask_t g_mask  [MAX_OPS];
  xlen_t      g_tdata [MAX_OPS];
  int         n_ops;
  int         mismatches;
  int         timeouts;
  int         other_errors;
  int         assert_fails;

  mem_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    wait (n_ops > 0);
    #(PERIOD * n_ops * 30);
    $display("watchdog expired after %0d cycles, run did not finish", n_ops * 30);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          cnt;
    string       line;
    logic [63:0] f [9];
    fd = $fopen("mem_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open mem_golden.txt");
      return;
    end
    while (!$feof(fd) && n_ops < MAX_OPS) begin
      line = "";
      cnt = $fgets(line, fd);
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (cnt == 9) begin
        g_op[n_ops]    = f[0][3:0];
        g_addr[n_ops]  = f[1];
        g_sdata[n_ops] = f[2];
        g_rd[n_ops]    = f[3][4:0];
        g_we[n_ops]    = f[4][0];
        g_stall[n_ops] = int'(f[5]);
        g_wb[n_ops]    = f[6];
        g_mask[n_ops]  = f[7][7:0];
        g_tdata[n_ops] = f[8];
        n_ops++;
      end
    end
    $fclose(fd);
  endtask

  // polls at the falling edge where outputs have settled
  task automatic wait_handshake(input bit for_wb, input string tag, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < HS_CAP && !ok; n++) begin
      @(negedge clk);
      ok = for_wb ? (wb_valid === 1'b1) : (mem_allowin === 1'b1);
    end
    if (!ok) begin
      timeouts++;
      $display("%s: handshake timed out waiting for %s", tag,
               for_wb ? "wb_valid" : "mem_allowin");
    end
  endtask

  task automatic run_op(input int i);
    bit    ok;
    bit    is_ld;
    bit    is_st;
    xlen_t pc;
    string tag;
    is_ld = (g_op[i] >= 4'd1) && (g_op[i] <= 4'd7);
    is_st = (g_op[i] >= 4'd8) && (g_op[i] <= 4'd11);
    pc    = 64'h8000_0000 + 64'(4 * i);
    tag   = $sformatf("op%0d", i);
    ex_valid      = 1'b1;
    ex_op         = mem_op_e'(g_op[i]);
    ex_pc         = pc;
    ex_addr       = g_addr[i];
    ex_store_data = g_sdata[i];
    ex_rd_addr    = g_rd[i];
    ex_rd_we      = g_we[i];
    wait_handshake(1'b0, tag, ok);
    if (ok) begin
      @(posedge clk);
      #2;
      ex_valid   = 1'b0;
      wb_allowin = 1'b0;
      wait_handshake(1'b1, tag, ok);
    end
    if (!ok) begin
      @(posedge clk);
      #2;
      ex_valid   = 1'b0;
      wb_allowin = 1'b1;
      return;
    end
    check_val({tag, " wb_data"}, g_wb[i], wb_data);
    check_val({tag, " wb_pc"}, pc, wb_pc);
    check_val({tag, " wb_rd_addr"}, g_rd[i], wb_rd_addr);
    check_val({tag, " wb_rd_we"}, g_we[i], wb_rd_we);
    check_val({tag, " fwd_rd_addr"}, g_rd[i], fwd_rd_addr);
    check_val({tag, " fwd_rd_we"}, g_we[i], fwd_rd_we);
    check_val({tag, " fwd_is_load"}, is_ld, fwd_is_load);
    check_val({tag, " fwd_data"}, g_addr[i], fwd_data);
    check_val({tag, " trace_st_valid"}, is_st, trace_st_valid);
    if (is_st) begin
      check_val({tag, " trace_addr"}, g_addr[i] & ~64'h7, trace_addr);
      check_val({tag, " trace_mask"}, g_mask[i], trace_mask);
      check_val({tag, " trace_data"}, g_tdata[i], trace_data);
    end
    repeat (g_stall[i]) begin
      @(negedge clk);
      check_val({tag, " held wb_valid"}, 1, wb_valid);
      check_val({tag, " held wb_data"}, g_wb[i], wb_data);
    end
    // next op is driven in this same cycle
    @(posedge clk);
    #2;
    wb_allowin = 1'b1;
  endtask

  initial begin
    rst           = 1'b1;
    ex_valid      = 1'b0;
    ex_pc         = '0;
    ex_op         = NONE;
    ex_addr       = '0;
    ex_store_data = '0;
    ex_rd_addr    = '0;
    ex_rd_we      = 1'b0;
    wb_allowin    = 1'b0;
    load_golden();
    if (n_ops == 0) begin
      other_errors++;
      $display("no operations were read from mem_golden.txt");
    end
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_val("reset mem_allowin", 1, mem_allowin);
    check_val("reset wb_valid", 0, wb_valid);
    @(posedge clk);
    #2;
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    @(posedge clk);
    #2;
    wb_allowin = 1'b0;
    repeat (2) @(posedge clk);
    assert_fails = i_dut.u_mem_stage.i_chk.fail_cnt;
    $display("errors: %0d mismatches, %0d handshake timeouts, %0d assertion failures, %0d other",
             mismatches, timeouts, assert_fails, other_errors);
    if (mismatches + timeouts + assert_fails + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- mem_top.sv
`timescale 1ns/1ps

module mem_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                ex_valid,
  input  mem_pkg::xlen_t      ex_pc,
  input  mem_pkg::mem_op_e    ex_op,
  input  mem_pkg::xlen_t      ex_addr,
  input  mem_pkg::xlen_t      ex_store_data,
  input  mem_pkg::reg_addr_t  ex_rd_addr,
  input  logic                ex_rd_we,
  output logic                mem_allowin,
  output logic                wb_valid,
  output mem_pkg::xlen_t      wb_pc,
  output mem_pkg::reg_addr_t  wb_rd_addr,
  output logic                wb_rd_we,
  output mem_pkg::xlen_t      wb_data,
  input  logic                wb_allowin,
  output mem_pkg::reg_addr_t  fwd_rd_addr,
  output logic                fwd_rd_we,
  output logic                fwd_is_load,
  output mem_pkg::xlen_t      fwd_data,
  output logic                trace_st_valid,
  output mem_pkg::xlen_t      trace_addr,
  output mem_pkg::xlen_t      trace_data,
  output mem_pkg::byte_mask_t trace_mask
);

  mem_rw_if mem_if ();

  mem_stage u_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .ex_valid       (ex_valid),
    .ex_pc          (ex_pc),
    .ex_op          (ex_op),
    .ex_addr        (ex_addr),
    .ex_store_data  (ex_store_data),
    .ex_rd_addr     (ex_rd_addr),
    .ex_rd_we       (ex_rd_we),
    .mem_allowin    (mem_allowin),
    .wb_valid       (wb_valid),
    .wb_pc          (wb_pc),
    .wb_rd_addr     (wb_rd_addr),
    .wb_rd_we       (wb_rd_we),
    .wb_data        (wb_data),
    .wb_allowin     (wb_allowin),
    .fwd_rd_addr    (fwd_rd_addr),
    .fwd_rd_we      (fwd_rd_we),
    .fwd_is_load    (fwd_is_load),
    .fwd_data       (fwd_data),
    .trace_st_valid (trace_st_valid),
    .trace_addr     (trace_addr),
    .trace_data     (trace_data),
    .trace_mask     (trace_mask),
    .mem            (mem_if.master)
  );

  data_ram u_data_ram (
    .clk (clk),
    .rst (rst),
    .mem (mem_if.slave)
  );

endmodule

//--- store_lane_align.sv
`timescale 1ns/1ps

module store_lane_align (
  input  mem_pkg::mem_size_e  size,
  input  logic [2:0]          addr_low,
  input  mem_pkg::xlen_t      data,
  output mem_pkg::xlen_t      lane_data,
  output mem_pkg::byte_mask_t lane_mask
);
  import mem_pkg::*;

  xlen_t      repl;
  byte_mask_t size_mask;

  // low bytes copied into every lane of the word
  always_comb begin
    case (size)
      SIZE_B: begin
        repl      = {8{data[7:0]}};
        size_mask = 8'b0000_0001;
      end
      SIZE_H: begin
        repl      = {4{data[15:0]}};
        size_mask = 8'b0000_0011;
      end
      SIZE_W: begin
        repl      = {2{data[31:0]}};
        size_mask = 8'b0000_1111;
      end
      default: begin
        repl      = data;
        size_mask = 8'b1111_1111;
      end
    endcase
  end

  assign lane_mask = size_mask << addr_low;

  // untouched lanes read as zero
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      lane_data[8*i +: 8] = lane_mask[i] ? repl[8*i +: 8] : 8'h00;
    end
  end

endmodule
